// File: im_pkg.sv
`default_nettype none

package im_pkg;

    // frame geometry
    localparam int IN_W     = 16;
    localparam int IN_H     = 8;
    localparam int AREA     = 4;
    localparam int OUT_W    = IN_W / AREA;
    localparam int OUT_H    = IN_H / AREA;
    localparam int AREA_PIX = AREA * AREA;
    localparam int OUT_PIX  = OUT_W * OUT_H;

    localparam int CH_W   = 8;
    localparam int PIX_W  = 3 * CH_W;
    localparam int ADDR_W = 16;
    localparam int SUM_W  = CH_W + $clog2(AREA_PIX);   // 16 values per channel

    // counter widths
    localparam int CNT_AW = $clog2(AREA);       // column / row inside an area
    localparam int OX_W   = $clog2(OUT_W);
    localparam int OY_W   = $clog2(OUT_H);
    localparam int PIX_CW = $clog2(AREA_PIX);
    localparam int OCNT_W = $clog2(OUT_PIX);

    // apb register map
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;
    localparam logic [APB_AW-1:0] REG_SRC    = 4'h0;
    localparam logic [APB_AW-1:0] REG_DST    = 4'h4;
    localparam logic [APB_AW-1:0] REG_CTRL   = 4'h8;
    localparam logic [APB_AW-1:0] REG_STATUS = 4'hC;
    localparam int ST_BUSY_BIT = 0;
    localparam int ST_DONE_BIT = 1;

    typedef struct packed {
        logic [CH_W-1:0] r;     // top byte
        logic [CH_W-1:0] g;
        logic [CH_W-1:0] b;
    } rgb_t;

    typedef union packed {
        logic [PIX_W-1:0] raw;
        rgb_t             ch;
    } pixel_u;

    // pix[0] is the first pixel of the area in raster order
    typedef struct packed {
        logic                   valid;
        pixel_u [AREA_PIX-1:0] pix;
    } area_t;

    typedef struct packed {
        logic   valid;
        pixel_u pix;
    } mean_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        pixel_u            data;
    } wr_req_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: im_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module im_apb_regs import im_pkg::*; (
    input  logic              iclk,
    input  logic              i_rst_n,
    input  apb_req_t          i_apb,
    input  logic              i_frame_done,
    output apb_rsp_t          o_apb,
    output logic              o_start,
    output logic [ADDR_W-1:0] o_src_base,
    output logic [ADDR_W-1:0] o_dst_base
);

    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic              busy_q;
    logic              done_q;
    logic              access;
    logic              wr_access;
    logic              start_req;
    logic              mapped;
    logic [APB_DW-1:0] rdata;

    assign access    = i_apb.psel & i_apb.penable;  // access phase, no wait states
    assign wr_access = access & i_apb.pwrite;
    assign start_req = wr_access && (i_apb.paddr == REG_CTRL) && i_apb.pwdata[0];

    // refused while a frame is running
    assign o_start = start_req & ~busy_q;

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (i_apb.paddr)
            REG_SRC:    rdata = APB_DW'(src_q);
            REG_DST:    rdata = APB_DW'(dst_q);
            REG_CTRL:   rdata = '0;     // start bit is write-only
            REG_STATUS: begin
                rdata[ST_BUSY_BIT] = busy_q;
                rdata[ST_DONE_BIT] = done_q;
            end
            default:    mapped = 1'b0;
        endcase
    end

    assign o_apb = '{
        prdata:  rdata,
        pready:  1'b1,
        pslverr: access & (~mapped | (start_req & busy_q))
    };

    always_ff @(posedge iclk) begin
        if (!i_rst_n) begin
            src_q  <= '0;
            dst_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (wr_access && i_apb.paddr == REG_SRC) begin
                src_q <= i_apb.pwdata[ADDR_W-1:0];
            end
            if (wr_access && i_apb.paddr == REG_DST) begin
                dst_q <= i_apb.pwdata[ADDR_W-1:0];
            end

            if (o_start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (i_frame_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;     // sticky until next start
            end
        end
    end

    assign o_src_base = src_q;
    assign o_dst_base = dst_q;

    a_penable_psel: assert property (
        @(posedge iclk) disable iff (!i_rst_n)
        i_apb.penable |-> i_apb.psel
    );

    // the writer only finishes a frame that was started here
    a_done_while_busy: assert property (
        @(posedge iclk) disable iff (!i_rst_n)
        i_frame_done |-> busy_q
    );

endmodule

`default_nettype wire

// File: block_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module block_fetch import im_pkg::*; (
    input  logic              iclk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  logic [ADDR_W-1:0] i_src_base,
    input  pixel_u            i_rd_data,
    output rd_req_t           o_rd,
    output area_t             o_area
);

    // position of the pixel currently on o_rd
    logic [CNT_AW-1:0] col_q;
    logic [CNT_AW-1:0] row_q;
    logic [OX_W-1:0]   ax_q;
    logic [OY_W-1:0]   ay_q;
    logic [CNT_AW-1:0] col_n;
    logic [CNT_AW-1:0] row_n;
    logic [OX_W-1:0]   ax_n;
    logic [OY_W-1:0]   ay_n;
    logic              last_pix;

    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] next_x;
    logic [ADDR_W-1:0] next_y;
    logic [ADDR_W-1:0] next_addr;

    logic                   rd_en_q;
    logic [ADDR_W-1:0]      rd_addr_q;
    logic                   rd_en_d;    // data on i_rd_data this cycle
    logic [PIX_CW-1:0]      got_q;
    logic                   area_vld_q;
    pixel_u [AREA_PIX-1:0] area_pix_q;

    always_comb begin
        col_n    = col_q;
        row_n    = row_q;
        ax_n     = ax_q;
        ay_n     = ay_q;
        last_pix = 1'b0;
        if (col_q != CNT_AW'(AREA - 1)) begin
            col_n = col_q + 1'b1;
        end else begin
            col_n = '0;
            if (row_q != CNT_AW'(AREA - 1)) begin
                row_n = row_q + 1'b1;
            end else begin
                row_n = '0;     // area finished
                if (ax_q != OX_W'(OUT_W - 1)) begin
                    ax_n = ax_q + 1'b1;
                end else begin
                    ax_n = '0;  // band finished
                    if (ay_q != OY_W'(OUT_H - 1)) begin
                        ay_n = ay_q + 1'b1;
                    end else begin
                        ay_n     = '0;
                        last_pix = 1'b1;
                    end
                end
            end
        end
    end

    assign next_x    = ADDR_W'(ax_n) * ADDR_W'(AREA) + ADDR_W'(col_n);
    assign next_y    = ADDR_W'(ay_n) * ADDR_W'(AREA) + ADDR_W'(row_n);
    assign next_addr = base_q + next_y * ADDR_W'(IN_W) + next_x;

    always_ff @(posedge iclk) begin
        if (!i_rst_n) begin
            rd_en_q    <= 1'b0;
            rd_en_d    <= 1'b0;
            col_q      <= '0;
            row_q      <= '0;
            ax_q       <= '0;
            ay_q       <= '0;
            got_q      <= '0;
            area_vld_q <= 1'b0;
        end else begin
            rd_en_d    <= rd_en_q;
            area_vld_q <= 1'b0;
            if (i_start) begin
                rd_en_q <= 1'b1;
                col_q   <= '0;
                row_q   <= '0;
                ax_q    <= '0;
                ay_q    <= '0;
            end else if (rd_en_q) begin
                col_q <= col_n;
                row_q <= row_n;
                ax_q  <= ax_n;
                ay_q  <= ay_n;
                if (last_pix) begin
                    rd_en_q <= 1'b0;    // frame fully requested
                end
            end

            if (rd_en_d) begin
                if (got_q == PIX_CW'(AREA_PIX - 1)) begin
                    got_q      <= '0;
                    area_vld_q <= 1'b1;
                end else begin
                    got_q <= got_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge iclk) begin
        if (i_start) begin
            base_q    <= i_src_base;
            rd_addr_q <= i_src_base;
        end else if (rd_en_q) begin
            rd_addr_q <= next_addr;
        end
        if (rd_en_d) begin
            area_pix_q <= {i_rd_data, area_pix_q[AREA_PIX-1:1]};  // first pixel ends at 0
        end
    end

    assign o_rd   = '{en: rd_en_q, addr: rd_addr_q};
    assign o_area = '{valid: area_vld_q, pix: area_pix_q};

    // reads stay inside the source frame
    a_rd_in_frame: assert property (
        @(posedge iclk) disable iff (!i_rst_n)
        rd_en_q |-> (rd_addr_q - base_q) < ADDR_W'(IN_W * IN_H)
    );

endmodule

`default_nettype wire

// File: mean_tree.sv
`timescale 1ns/100ps
`default_nettype none

module mean_tree import im_pkg::*; (
    input  logic  iclk,
    input  logic  i_rst_n,
    input  area_t i_area,
    output mean_t o_mean
);

    logic [CH_W-1:0]  ch_in [3][AREA_PIX];     // 0 = r, 1 = g, 2 = b
    logic [CH_W:0]    s1_q  [3][AREA_PIX/2];
    logic [CH_W+1:0]  s2_q  [3][AREA_PIX/4];
    logic [CH_W+2:0]  s3_q  [3][AREA_PIX/8];
    logic [SUM_W-1:0] s4    [3];
    logic [3:0]       vld_q;
    pixel_u           mean_q;

    always_comb begin
        for (int i = 0; i < AREA_PIX; i++) begin
            ch_in[0][i] = i_area.pix[i].ch.r;
            ch_in[1][i] = i_area.pix[i].ch.g;
            ch_in[2][i] = i_area.pix[i].ch.b;
        end
    end

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            s4[c] = {1'b0, s3_q[c][0]} + {1'b0, s3_q[c][1]};
        end
    end

    always_ff @(posedge iclk) begin
        if (!i_rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[2:0], i_area.valid};
        end
    end

    // pairwise adds, one bit wider per stage
    always_ff @(posedge iclk) begin
        for (int c = 0; c < 3; c++) begin
            if (i_area.valid) begin
                for (int i = 0; i < AREA_PIX/2; i++) begin
                    s1_q[c][i] <= {1'b0, ch_in[c][2*i]} + {1'b0, ch_in[c][2*i+1]};
                end
            end
            if (vld_q[0]) begin
                for (int i = 0; i < AREA_PIX/4; i++) begin
                    s2_q[c][i] <= {1'b0, s1_q[c][2*i]} + {1'b0, s1_q[c][2*i+1]};
                end
            end
            if (vld_q[1]) begin
                for (int i = 0; i < AREA_PIX/8; i++) begin
                    s3_q[c][i] <= {1'b0, s2_q[c][2*i]} + {1'b0, s2_q[c][2*i+1]};
                end
            end
        end
        if (vld_q[2]) begin
            mean_q.ch.r <= s4[0][SUM_W-1 -: CH_W];  // floor of sum / 16
            mean_q.ch.g <= s4[1][SUM_W-1 -: CH_W];
            mean_q.ch.b <= s4[2][SUM_W-1 -: CH_W];
        end
    end

    assign o_mean = '{valid: vld_q[3], pix: mean_q};

endmodule

`default_nettype wire

// File: pixel_writer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_writer import im_pkg::*; (
    input  logic              iclk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  logic [ADDR_W-1:0] i_dst_base,
    input  mean_t             i_mean,
    output wr_req_t           o_wr,
    output logic              o_frame_done
);

    logic [OCNT_W-1:0] cnt_q;
    logic [ADDR_W-1:0] dst_q;       // base latched at start
    logic              wr_en_q;
    logic [ADDR_W-1:0] wr_addr_q;
    pixel_u            wr_data_q;
    logic              done_q;

    always_ff @(posedge iclk) begin
        if (!i_rst_n) begin
            cnt_q   <= '0;
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            wr_en_q <= i_mean.valid;
            done_q  <= i_mean.valid && (cnt_q == OCNT_W'(OUT_PIX - 1));
            if (i_start) begin
                cnt_q <= '0;
            end else if (i_mean.valid) begin
                cnt_q <= (cnt_q == OCNT_W'(OUT_PIX - 1)) ? '0 : cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge iclk) begin
        if (i_start) begin
            dst_q <= i_dst_base;
        end
        if (i_mean.valid) begin
            wr_addr_q <= dst_q + ADDR_W'(cnt_q);
            wr_data_q <= i_mean.pix;
        end
    end

    assign o_wr         = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};
    assign o_frame_done = done_q;   // same cycle as last write

    // a new frame never cuts into a running one
    a_start_idle: assert property (
        @(posedge iclk) disable iff (!i_rst_n)
        i_start |-> cnt_q == '0
    );

endmodule

`default_nettype wire

// File: im_compression.sv
`timescale 1ns/100ps
`default_nettype none

module im_compression import im_pkg::*; (
    input  logic     iclk,
    input  logic     i_rst_n,
    input  apb_req_t i_apb,
    input  pixel_u   i_rd_data,
    output apb_rsp_t o_apb,
    output rd_req_t  o_rd,
    output wr_req_t  o_wr
);

    logic              start;
    logic              frame_done;
    logic [ADDR_W-1:0] src_base;
    logic [ADDR_W-1:0] dst_base;
    area_t             area;
    mean_t             mean;

    im_apb_regs u_regs (
        .iclk         (iclk),
        .i_rst_n      (i_rst_n),
        .i_apb        (i_apb),
        .i_frame_done (frame_done),
        .o_apb        (o_apb),
        .o_start      (start),
        .o_src_base   (src_base),
        .o_dst_base   (dst_base)
    );

    block_fetch u_fetch (
        .iclk       (iclk),
        .i_rst_n    (i_rst_n),
        .i_start    (start),
        .i_src_base (src_base),
        .i_rd_data  (i_rd_data),
        .o_rd       (o_rd),
        .o_area     (area)
    );

    mean_tree u_tree (
        .iclk    (iclk),
        .i_rst_n (i_rst_n),
        .i_area  (area),
        .o_mean  (mean)
    );

    pixel_writer u_writer (
        .iclk         (iclk),
        .i_rst_n      (i_rst_n),
        .i_start      (start),
        .i_dst_base   (dst_base),
        .i_mean       (mean),
        .o_wr         (o_wr),
        .o_frame_done (frame_done)
    );

endmodule

`default_nettype wire

// File: tb_tasks.svh
// galois form with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);     // one step per bit
        r      = {r[30:0], lfsr_q[0]};
    end
    return r;
endfunction

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_pixel(input string name, input pixel_u got, input pixel_u exp);
    if (got !== exp) begin
        fail_run($sformatf("Fail %s got %h expected %h", name, got.raw, exp.raw));
    end
endtask

task automatic check_word(input string name, input logic [APB_DW-1:0] got,
                          input logic [APB_DW-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
endtask

// setup cycle then access cycle until pready
task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge iclk);
    apb_in = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge iclk);
    apb_in.penable = 1'b1;
    #1;
    while (!apb_out.pready) begin
        if (waited == APB_TIMEOUT) begin
            fail_run("APB access never saw pready");
        end
        @(negedge iclk);
        #1;
        waited++;
    end
    rdata = apb_out.prdata;
    err   = apb_out.pslverr;
    @(negedge iclk);
    apb_in = '0;
endtask

task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                         output logic err);
    logic [APB_DW-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
endtask

task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                        output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
endtask

task automatic write_expect(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                            input logic exp_err, input string name);
    logic err;
    apb_write(addr, data, err);
    check_bit({name, " pslverr"}, err, exp_err);
endtask

task automatic read_expect(input logic [APB_AW-1:0] addr, input string name,
                           input logic [APB_DW-1:0] exp);
    logic [APB_DW-1:0] d;
    logic              err;
    apb_read(addr, d, err);
    check_bit({name, " pslverr"}, err, 1'b0);
    check_word(name, d, exp);
endtask

task automatic wait_frame_done();
    logic [APB_DW-1:0] st;
    logic              err;
    int                polls;
    st    = '0;
    polls = 0;
    while (!st[ST_DONE_BIT]) begin
        if (polls == DONE_TIMEOUT) begin
            fail_run("frame never reported done in STATUS");
        end
        apb_read(REG_STATUS, st, err);
        check_bit("STATUS pslverr", err, 1'b0);
        polls++;
    end
endtask

task automatic fill_dst_markers();
    @(posedge iclk);
    dst_fill_req = 1'b1;
    @(posedge iclk);
    dst_fill_req = 1'b0;
endtask

task automatic fill_random();
    for (int i = 0; i < MEM_DEPTH; i++) begin
        src_mem[i].raw = PIX_W'(rand_bits(PIX_W));
    end
endtask

// floor of the channel sum over the area, divided by 16
function automatic pixel_u expected_pixel(int k, logic [ADDR_W-1:0] base);
    int     ax;
    int     ay;
    int     a;
    int     sr;
    int     sg;
    int     sb;
    pixel_u p;
    pixel_u e;
    ax = k % OUT_W;
    ay = k / OUT_W;
    sr = 0;
    sg = 0;
    sb = 0;
    for (int y = 0; y < AREA; y++) begin
        for (int x = 0; x < AREA; x++) begin
            a  = int'(base) + (ay * AREA + y) * IN_W + ax * AREA + x;
            p  = src_mem[a];
            sr += int'(p.ch.r);
            sg += int'(p.ch.g);
            sb += int'(p.ch.b);
        end
    end
    e.ch.r = CH_W'(sr / AREA_PIX);
    e.ch.g = CH_W'(sg / AREA_PIX);
    e.ch.b = CH_W'(sb / AREA_PIX);
    return e;
endfunction

task automatic run_frame(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst);
    write_expect(REG_SRC, APB_DW'(src), 1'b0, "SRC");
    write_expect(REG_DST, APB_DW'(dst), 1'b0, "DST");
    write_expect(REG_CTRL, 32'h1, 1'b0, "CTRL start");
    wait_frame_done();
endtask

// results inside the window and markers everywhere else
task automatic check_frame(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst);
    int d0;
    d0 = int'(dst);
    for (int k = 0; k < OUT_PIX; k++) begin
        check_pixel($sformatf("dst_mem[%0d]", d0 + k), dst_mem[d0 + k],
                    expected_pixel(k, src));
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
        if (i < d0 || i >= d0 + OUT_PIX) begin
            check_pixel($sformatf("dst_mem[%0d]", i), dst_mem[i], marker(i));
        end
    end
endtask

task automatic test_reset_regs();
    logic [APB_DW-1:0] d;
    logic              err;
    read_expect(REG_SRC, "SRC", '0);
    read_expect(REG_DST, "DST", '0);
    read_expect(REG_STATUS, "STATUS", '0);
    write_expect(REG_SRC, 32'hdead_1234, 1'b0, "SRC");
    read_expect(REG_SRC, "SRC", 32'h0000_1234);     // only ADDR_W bits kept
    write_expect(REG_DST, 32'h0000_0abc, 1'b0, "DST");
    read_expect(REG_DST, "DST", 32'h0000_0abc);
    apb_read(4'h2, d, err);
    check_bit("unmapped pslverr", err, 1'b1);
endtask

task automatic test_const_frame();
    pixel_u c;
    c.raw = 24'h5a_c3_17;
    for (int i = 0; i < MEM_DEPTH; i++) begin
        src_mem[i] = c;
    end
    fill_dst_markers();
    run_frame(16'h0000, 16'h0000);
    for (int k = 0; k < OUT_PIX; k++) begin
        check_pixel($sformatf("dst_mem[%0d]", k), dst_mem[k], c);
    end
    check_frame(16'h0000, 16'h0000);
endtask

task automatic test_random_frame();
    fill_random();
    fill_dst_markers();
    run_frame(16'h0000, 16'h0000);
    check_frame(16'h0000, 16'h0000);
endtask

task automatic test_offset_bases();
    fill_random();
    fill_dst_markers();
    run_frame(16'h0060, 16'h00a4);
    check_frame(16'h0060, 16'h00a4);
endtask

task automatic test_control();
    fill_random();
    fill_dst_markers();
    write_expect(REG_SRC, 32'h0000_0010, 1'b0, "SRC");
    write_expect(REG_DST, 32'h0000_0020, 1'b0, "DST");
    write_expect(REG_CTRL, 32'h1, 1'b0, "CTRL start");
    check_bit("o_rd.en", rd_req.en, 1'b1);     // reads begin right after the start edge
    read_expect(REG_CTRL, "CTRL", '0);         // start bit reads as 0 after a write
    read_expect(REG_STATUS, "STATUS", APB_DW'(1) << ST_BUSY_BIT);
    write_expect(REG_CTRL, 32'h1, 1'b1, "CTRL restart");
    wait_frame_done();
    read_expect(REG_STATUS, "STATUS", APB_DW'(1) << ST_DONE_BIT);
    check_frame(16'h0010, 16'h0020);
endtask

task automatic test_second_frame();
    fill_random();
    fill_dst_markers();
    write_expect(REG_CTRL, 32'h1, 1'b0, "CTRL start");
    read_expect(REG_STATUS, "STATUS", APB_DW'(1) << ST_BUSY_BIT);   // done cleared
    wait_frame_done();
    read_expect(REG_STATUS, "STATUS", APB_DW'(1) << ST_DONE_BIT);
    check_frame(16'h0010, 16'h0020);   // bases kept from the last frame
endtask

// File: tb_im_compression.sv
`timescale 1ns/100ps
`default_nettype none

module tb_im_compression import im_pkg::*; ();

    localparam int          MEM_DEPTH    = 256;
    localparam int          MEM_AW       = 8;
    localparam int          RST_CYCLES   = 10;
    localparam int          APB_TIMEOUT  = 16;
    localparam int          DONE_TIMEOUT = 100;    // status polls, 3 cycles each
    localparam logic [31:0] LFSR_SEED    = 32'h11a7_5ca0;

    logic        iclk;
    logic        i_rst_n;
    apb_req_t    apb_in;
    apb_rsp_t    apb_out;
    pixel_u      rd_data      = '0;
    rd_req_t     rd_req;
    wr_req_t     wr_req;
    rd_req_t     rd_pend      = '0;
    logic        dst_fill_req = 1'b0;
    logic [31:0] lfsr_q;
    pixel_u      src_mem [MEM_DEPTH];
    pixel_u      dst_mem [MEM_DEPTH];

    im_compression i_dut (
        .iclk      (iclk),
        .i_rst_n   (i_rst_n),
        .i_apb     (apb_in),
        .i_rd_data (rd_data),
        .o_apb     (apb_out),
        .o_rd      (rd_req),
        .o_wr      (wr_req)
    );

    // marker carries its own address so a stray write shows up
    function automatic pixel_u marker(int a);
        pixel_u m;
        m.raw = {16'hc35a, 8'(a)};
        return m;
    endfunction

    `include "tb_tasks.svh"

    initial begin
        iclk = 1'b0;
        forever begin
            #4 iclk = ~iclk;
        end
    end

    // source memory, data one cycle after the request
    always @(negedge iclk) begin
        if (rd_req.en && rd_req.addr >= ADDR_W'(MEM_DEPTH)) begin
            fail_run("read request outside the source memory");
        end
        if (rd_pend.en) begin
            rd_data <= src_mem[rd_pend.addr[MEM_AW-1:0]];
        end
        rd_pend <= rd_req;
    end

    // destination memory
    always @(negedge iclk) begin
        if (dst_fill_req) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                dst_mem[i] <= marker(i);
            end
        end else if (wr_req.en) begin
            if (wr_req.addr >= ADDR_W'(MEM_DEPTH)) begin
                fail_run("write request outside the destination memory");
            end
            dst_mem[wr_req.addr[MEM_AW-1:0]] <= wr_req.data;
        end
    end

    initial begin
        i_rst_n = 1'b0;
        apb_in  = '0;
        lfsr_q  = LFSR_SEED;
        repeat (RST_CYCLES) @(negedge iclk);
        i_rst_n = 1'b1;

        test_reset_regs();
        test_const_frame();
        test_random_frame();
        test_offset_bases();
        test_control();
        test_second_frame();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
im_pkg.sv
im_apb_regs.sv
block_fetch.sv
mean_tree.sv
pixel_writer.sv
im_compression.sv
tb_im_compression.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_im_compression \
    -f all.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qF "** PASS **" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
